//--- rtl/exu.sv
module exu import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,

    // decoded instruction in
    input  logic     ex_vld_i,
    output logic     ex_rdy_o,
    input  dec2ex_s  ex_info_i,

    // data memory
    output logic     mem_cmd_vld_o,
    input  logic     mem_cmd_rdy_i,
    output mem_cmd_s mem_cmd_o,
    input  logic     mem_rsp_vld_i,
    output logic     mem_rsp_rdy_o,
    input  data_t    mem_rsp_rdata_i,

    // register file
    output logic     reg_wen_o,
    output reg_idx_t reg_waddr_o,
    output data_t    reg_wdata_o,

    output logic     fault_o
);

    // ****************************************
    // unit hookup
    // ****************************************
    logic alu_vld;
    logic alu_rdy;
    logic lsu_vld;
    logic lsu_rdy;

    logic alu_wb_vld;
    logic alu_wb_rdy;
    wb_s  alu_wb;
    logic lsu_wb_vld;
    logic lsu_wb_rdy;
    wb_s  lsu_wb;

    exu_disp disp0 (
        .clk(clk), .rst_i(rst_i),
        .ex_vld_i(ex_vld_i), .ex_rdy_o(ex_rdy_o), .ex_grp_i(ex_info_i.grp),
        .alu_vld_o(alu_vld), .alu_rdy_i(alu_rdy),
        .lsu_vld_o(lsu_vld), .lsu_rdy_i(lsu_rdy),
        .fault_o(fault_o)
    );

    exu_alu alu0 (
        .clk(clk), .rst_i(rst_i),
        .alu_vld_i(alu_vld), .alu_rdy_o(alu_rdy), .ex_info_i(ex_info_i),
        .wb_vld_o(alu_wb_vld), .wb_rdy_i(alu_wb_rdy), .wb_o(alu_wb)
    );

    exu_lsu lsu0 (
        .clk(clk), .rst_i(rst_i),
        .lsu_vld_i(lsu_vld), .lsu_rdy_o(lsu_rdy), .ex_info_i(ex_info_i),
        .mem_cmd_vld_o(mem_cmd_vld_o), .mem_cmd_rdy_i(mem_cmd_rdy_i), .mem_cmd_o(mem_cmd_o),
        .mem_rsp_vld_i(mem_rsp_vld_i), .mem_rsp_rdy_o(mem_rsp_rdy_o),
        .mem_rsp_rdata_i(mem_rsp_rdata_i),
        .wb_vld_o(lsu_wb_vld), .wb_rdy_i(lsu_wb_rdy), .wb_o(lsu_wb)
    );

    exu_wbck wbck0 (
        .alu_vld_i(alu_wb_vld), .alu_rdy_o(alu_wb_rdy), .alu_wb_i(alu_wb),
        .lsu_vld_i(lsu_wb_vld), .lsu_rdy_o(lsu_wb_rdy), .lsu_wb_i(lsu_wb),
        .reg_wen_o(reg_wen_o), .reg_waddr_o(reg_waddr_o), .reg_wdata_o(reg_wdata_o)
    );

endmodule

//--- rtl/exu_alu.sv
module exu_alu import exu_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,

    input  logic    alu_vld_i,
    output logic    alu_rdy_o,
    input  dec2ex_s ex_info_i,

    output logic    wb_vld_o,
    input  logic    wb_rdy_i,
    output wb_s     wb_o
);

    data_t       op1;
    data_t       op2;
    logic [4:0]  shamt;
    data_t       res;
    logic        wb_vld_q;
    wb_s         wb_q;

    // ****************************************
    // operand select and compute
    // ****************************************
    assign op1   = ex_info_i.rs1;
    assign op2   = ex_info_i.use_imm ? ex_info_i.imm : ex_info_i.rs2;
    assign shamt = op2[4:0];   // rv32 shift range

    always_comb begin
        case (ex_info_i.alu_op)
            ALU_ADD: begin
                res = op1 + op2;
            end
            ALU_SUB: begin
                res = op1 - op2;
            end
            ALU_AND: res = op1 & op2;
            ALU_OR:  res = op1 | op2;
            ALU_XOR: res = op1 ^ op2;
            ALU_SLL: res = op1 << shamt;
            ALU_SRL: res = op1 >> shamt;
            ALU_SRA: begin
                res = data_t'($signed(op1) >>> shamt);
            end
            ALU_SLT: begin
                res = data_t'($signed(op1) < $signed(op2));
            end
            ALU_SLTU: begin
                res = data_t'(op1 < op2);
            end
            default: res = '0;
        endcase
    end

    // free slot, or the held result leaves this cycle
    assign alu_rdy_o = !wb_vld_q || wb_rdy_i;

    // ****************************************
    // output register
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_vld_q <= 1'b0;
        end else if (alu_vld_i && alu_rdy_o) begin
            wb_vld_q <= ex_info_i.rdwen;    // no item without a destination
        end else if (wb_rdy_i) begin
            wb_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_vld_i && alu_rdy_o) begin
            wb_q.rdidx <= ex_info_i.rdidx;
            wb_q.data  <= res;
        end
    end

    assign wb_vld_o = wb_vld_q;
    assign wb_o     = wb_q;

    // a stalled result must sit still until the arbiter takes it
    a_wb_hold: assert property (@(posedge clk) disable iff (rst_i)
        wb_vld_o && !wb_rdy_i |=> wb_vld_o && $stable(wb_o))
        else $error("alu write-back changed while stalled");

endmodule

//--- rtl/exu_disp.sv
module exu_disp import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,

    input  logic     ex_vld_i,
    output logic     ex_rdy_o,
    input  exu_grp_e ex_grp_i,

    output logic     alu_vld_o,
    input  logic     alu_rdy_i,
    output logic     lsu_vld_o,
    input  logic     lsu_rdy_i,

    output logic     fault_o
);

    logic is_alu;
    logic is_lsu;
    logic is_unknown;
    logic fault_q;

    // group decode
    assign is_alu     = (ex_grp_i == GRP_ALU);
    assign is_lsu     = (ex_grp_i == GRP_LSU);
    assign is_unknown = (ex_grp_i == GRP_RSV2) || (ex_grp_i == GRP_RSV3);

    assign alu_vld_o = ex_vld_i && is_alu;
    assign lsu_vld_o = ex_vld_i && is_lsu;

    // unknown groups are swallowed right away
    assign ex_rdy_o = is_alu ? alu_rdy_i :
                      is_lsu ? lsu_rdy_i : 1'b1;

    // ****************************************
    // fault pulse, one cycle after accept
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            fault_q <= 1'b0;
        end else begin
            fault_q <= ex_vld_i && ex_rdy_o && is_unknown;
        end
    end

    assign fault_o = fault_q;

    a_one_unit: assert property (@(posedge clk) disable iff (rst_i)
        !(alu_vld_o && lsu_vld_o))
        else $error("both units selected by dispatch");

endmodule

//--- rtl/exu_lsu.sv
module exu_lsu import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,

    input  logic     lsu_vld_i,
    output logic     lsu_rdy_o,
    input  dec2ex_s  ex_info_i,

    output logic     mem_cmd_vld_o,
    input  logic     mem_cmd_rdy_i,
    output mem_cmd_s mem_cmd_o,

    input  logic     mem_rsp_vld_i,
    output logic     mem_rsp_rdy_o,
    input  data_t    mem_rsp_rdata_i,

    output logic     wb_vld_o,
    input  logic     wb_rdy_i,
    output wb_s      wb_o
);

    lsu_state_e state_q;
    lsu_state_e state_d;
    addr_t      ea;
    wmask_t     mask_d;
    data_t      wdata_d;
    logic       misalign;
    mem_cmd_s   cmd_q;
    logic [1:0] lane_q;
    lsu_size_e  size_q;
    logic       unsign_q;
    logic       rdwen_q;
    wb_s        wb_q;
    data_t      lane_data;
    data_t      ld_data;

    // ****************************************
    // address, mask and store lanes
    // ****************************************
    assign ea = ex_info_i.rs1 + ex_info_i.imm;

    always_comb begin
        case (ex_info_i.lsu_size)
            SZ_B: begin
                mask_d   = wmask_t'(1) << ea[1:0];
                wdata_d  = {WMASK_W{ex_info_i.rs2[7:0]}};
                misalign = 1'b0;
            end
            SZ_H: begin
                mask_d   = wmask_t'(3) << ea[1:0];
                wdata_d  = {(WMASK_W / 2){ex_info_i.rs2[15:0]}};
                misalign = ea[0];
            end
            default: begin
                mask_d   = '1;
                wdata_d  = ex_info_i.rs2;
                misalign = |ea[1:0];
            end
        endcase
    end

    // load lane select and extension
    assign lane_data = mem_rsp_rdata_i >> {lane_q, 3'b000};

    always_comb begin
        case (size_q)
            SZ_B: ld_data = {{(XLEN-8){lane_data[7] & !unsign_q}}, lane_data[7:0]};
            SZ_H: ld_data = {{(XLEN-16){lane_data[15] & !unsign_q}}, lane_data[15:0]};
            default: ld_data = lane_data;
        endcase
    end

    // ****************************************
    // sequencer
    // ****************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            LSU_IDLE: if (lsu_vld_i) state_d = LSU_CMD;
            LSU_CMD:  if (mem_cmd_rdy_i) state_d = LSU_RSP;
            LSU_RSP: begin
                if (mem_rsp_vld_i) begin
                    state_d = (cmd_q.read && rdwen_q) ? LSU_WB : LSU_IDLE;  // stores end here
                end
            end
            LSU_WB:   if (wb_rdy_i) state_d = LSU_IDLE;
            default:  state_d = LSU_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= LSU_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (lsu_vld_i && lsu_rdy_o) begin
            cmd_q.read  <= !ex_info_i.lsu_store;
            cmd_q.addr  <= {ea[XLEN-1:2], 2'b00};
            cmd_q.wdata <= wdata_d;
            cmd_q.wmask <= ex_info_i.lsu_store ? mask_d : '0;
            lane_q      <= ea[1:0];
            size_q      <= ex_info_i.lsu_size;
            unsign_q    <= ex_info_i.lsu_unsign;
            rdwen_q     <= ex_info_i.rdwen;
            wb_q.rdidx  <= ex_info_i.rdidx;
        end
        if (mem_rsp_vld_i && mem_rsp_rdy_o) begin
            wb_q.data <= ld_data;
        end
    end

    assign lsu_rdy_o     = (state_q == LSU_IDLE);
    assign mem_cmd_vld_o = (state_q == LSU_CMD);
    assign mem_rsp_rdy_o = (state_q == LSU_RSP);
    assign wb_vld_o      = (state_q == LSU_WB);
    assign mem_cmd_o     = cmd_q;
    assign wb_o          = wb_q;

    a_aligned: assert property (@(posedge clk) disable iff (rst_i)
        lsu_vld_i && lsu_rdy_o |-> !misalign)
        else $error("misaligned access %h", ea);

    a_rsp_in_order: assert property (@(posedge clk) disable iff (rst_i)
        mem_rsp_vld_i |-> state_q == LSU_RSP)
        else $error("memory response with no command outstanding");

endmodule

//--- rtl/exu_pkg.sv
package exu_pkg;

    // ****************************************
    // widths
    // ****************************************
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int WMASK_W   = XLEN / 8;

    typedef logic [XLEN-1:0]      data_t;
    typedef logic [XLEN-1:0]      addr_t;     // byte address
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [WMASK_W-1:0]   wmask_t;    // one bit per byte lane

    // ****************************************
    // encodings
    // ****************************************
    typedef enum logic [1:0] {
        GRP_ALU  = 2'd0,
        GRP_LSU  = 2'd1,
        GRP_RSV2 = 2'd2,    // no unit behind these two
        GRP_RSV3 = 2'd3
    } exu_grp_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2
    } lsu_size_e;

    typedef enum logic [1:0] {
        LSU_IDLE, LSU_CMD, LSU_RSP, LSU_WB
    } lsu_state_e;

    // ****************************************
    // bundles
    // ****************************************
    typedef struct packed {
        exu_grp_e  grp;
        alu_op_e   alu_op;
        logic      use_imm;     // imm replaces rs2 in the ALU
        logic      lsu_store;
        lsu_size_e lsu_size;
        logic      lsu_unsign;  // zero-extend loads
        data_t     rs1;
        data_t     rs2;
        data_t     imm;
        logic      rdwen;
        reg_idx_t  rdidx;
    } dec2ex_s;

    typedef struct packed {
        reg_idx_t rdidx;
        data_t    data;
    } wb_s;

    typedef struct packed {
        logic   read;
        addr_t  addr;           // word aligned
        data_t  wdata;
        wmask_t wmask;
    } mem_cmd_s;

endpackage

//--- rtl/exu_wbck.sv
module exu_wbck import exu_pkg::*; (
    // alu side
    input  logic     alu_vld_i,
    output logic     alu_rdy_o,
    input  wb_s      alu_wb_i,

    // lsu side
    input  logic     lsu_vld_i,
    output logic     lsu_rdy_o,
    input  wb_s      lsu_wb_i,

    // register file write port
    output logic     reg_wen_o,
    output reg_idx_t reg_waddr_o,
    output data_t    reg_wdata_o
);

    logic lsu_win;
    logic alu_win;
    wb_s  sel_wb;

    // ****************************************
    // fixed priority, lsu first
    // ****************************************
    // the lsu holds a single access and would
    // block its whole pipe if it had to wait,
    // while the alu just keeps its output reg
    assign lsu_win = lsu_vld_i;
    assign alu_win = alu_vld_i && !lsu_vld_i;

    // lsu never waits
    assign lsu_rdy_o = 1'b1;
    assign alu_rdy_o = !lsu_vld_i;

    always_comb begin
        if (lsu_win) begin
            sel_wb = lsu_wb_i;
        end else begin
            sel_wb = alu_wb_i;
        end
    end

    // ****************************************
    // register write, same cycle as the grant
    // ****************************************
    assign reg_wen_o   = lsu_win || alu_win;
    assign reg_waddr_o = sel_wb.rdidx;
    assign reg_wdata_o = sel_wb.data;   // don't care when wen is low

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the exu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_exu -o tb_exu > build.log 2>&1 &&
    ./obj_dir/tb_exu > sim.log 2>&1 ||
    { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "All tests passed!" sim.log && echo "PASS" ||
    { echo "FAIL, see sim.log"; exit 1; }

//--- tb.f
rtl/exu_pkg.sv
rtl/exu_disp.sv
rtl/exu_alu.sv
rtl/exu_lsu.sv
rtl/exu_wbck.sv
rtl/exu.sv
tests/exu_mem_model.sv
tests/tb_exu.sv

//--- tests/exu_mem_model.sv
module exu_mem_model import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,

    input  logic     cmd_vld_i,
    output logic     cmd_rdy_o,
    input  mem_cmd_s cmd_i,

    output logic     rsp_vld_o,
    input  logic     rsp_rdy_i,
    output data_t    rsp_rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;

    data_t    mem [256];
    data_t    rsp_q[$];
    integer   seed = 32'h6ef3;
    int       cmd_dly;
    int       rsp_dly;
    logic     cmd_fire;
    logic     rsp_fire;
    mem_cmd_s cmd_s;
    logic [7:0] idx;

    initial begin
        for (int i = 0; i < 256; i++) begin
            idx = 8'(i);
            mem[i] = {idx ^ 8'h3c, ~idx, idx, idx + 8'h11};  // every byte tied to the address
        end
        cmd_rdy_o = 1'b0;
        rsp_vld_o = 1'b0;
        rsp_rdata_o = '0;
        cmd_fire = 1'b0;
        rsp_fire = 1'b0;
        cmd_dly = 0;
        rsp_dly = 0;
    end

    // handshakes seen at the edge
    always @(posedge clk) begin
        cmd_fire <= cmd_vld_i && cmd_rdy_o;
        rsp_fire <= rsp_vld_o && rsp_rdy_i;
        cmd_s    <= cmd_i;
    end

    // ****************************************
    // memory action and output drive
    // ****************************************
    always @(negedge clk) begin
        if (rst_i) begin
            cmd_rdy_o = 1'b0;
            rsp_vld_o = 1'b0;
            cmd_dly = 0;
            rsp_dly = 0;
            rsp_q.delete();
        end else begin
            if (rsp_fire) rsp_vld_o = 1'b0;
            if (cmd_fire) begin
                idx = cmd_s.addr[9:2];
                for (int k = 0; k < 4; k++) begin
                    if (!cmd_s.read && cmd_s.wmask[k]) begin
                        mem[idx][8*k +: 8] = cmd_s.wdata[8*k +: 8];
                    end
                end
                rsp_q.push_back(mem[idx]);    // stores get an answer too
                cmd_dly = {$random(seed)} % 4;
                rsp_dly = {$random(seed)} % 4;
            end
            if (cmd_dly > 0) begin
                cmd_rdy_o = 1'b0;
                cmd_dly--;
            end else begin
                cmd_rdy_o = 1'b1;
            end
            if (!rsp_vld_o && rsp_q.size() > 0) begin
                if (rsp_dly > 0) begin
                    rsp_dly--;
                end else begin
                    rsp_vld_o = 1'b1;
                    rsp_rdata_o = rsp_q.pop_front();
                end
            end
        end
    end

endmodule

//--- tests/tb_exu.sv
module tb_exu import exu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_MIXED = 200;
    localparam int TIMEOUT = 500;

    logic clk = 1'b0;
    logic rst_i = 1'b1;
    logic ex_vld_i = 1'b0;
    logic ex_rdy_o;
    dec2ex_s ex_info_i = '0;
    logic mem_cmd_vld_o, mem_cmd_rdy_i, mem_rsp_vld_i, mem_rsp_rdy_o;
    mem_cmd_s mem_cmd_o;
    data_t mem_rsp_rdata_i;
    logic reg_wen_o, fault_o;
    reg_idx_t reg_waddr_o;
    data_t reg_wdata_o;

    integer seed = 32'h6ef3;
    data_t shadow [256];
    wb_s alu_q[$];
    wb_s lsu_q[$];
    int mismatches = 0;
    int failures = 0;
    int faults_exp = 0;
    int faults_got = 0;
    logic ex_fire = 1'b0;
    logic wen_q = 1'b0;
    logic fault_q = 1'b0;
    wb_s got_q;

    exu dut0 (.*);

    exu_mem_model mem0 (
        .clk(clk), .rst_i(rst_i),
        .cmd_vld_i(mem_cmd_vld_o), .cmd_rdy_o(mem_cmd_rdy_i), .cmd_i(mem_cmd_o),
        .rsp_vld_o(mem_rsp_vld_i), .rsp_rdy_i(mem_rsp_rdy_o), .rsp_rdata_o(mem_rsp_rdata_i)
    );

    always #50 clk = ~clk;

    // ****************************************
    // reference model
    // ****************************************
    function automatic data_t exp_result(dec2ex_s info);
        data_t b;
        data_t w;
        addr_t a;
        b = info.use_imm ? info.imm : info.rs2;
        if (info.grp == GRP_LSU) begin
            a = info.rs1 + info.imm;
            w = shadow[a[9:2]] >> (int'(a[1:0]) * 8);
            if (info.lsu_size == SZ_B) begin
                return info.lsu_unsign ? {24'h0, w[7:0]} : {{24{w[7]}}, w[7:0]};
            end
            if (info.lsu_size == SZ_H) begin
                return info.lsu_unsign ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
            end
            return w;
        end
        case (info.alu_op)
            ALU_ADD:  return info.rs1 + b;
            ALU_SUB:  return info.rs1 + ~b + 32'd1;
            ALU_AND:  return info.rs1 & b;
            ALU_OR:   return info.rs1 | b;
            ALU_XOR:  return info.rs1 ^ b;
            ALU_SLL:  return info.rs1 << b[4:0];
            ALU_SRL:  return info.rs1 >> b[4:0];
            ALU_SRA:  return (info.rs1 >> b[4:0]) |
                             (info.rs1[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            ALU_SLT:  return ((info.rs1 ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            default:  return (info.rs1 < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic apply_store(dec2ex_s info);
        addr_t a;
        int lane;
        a = info.rs1 + info.imm;
        lane = int'(a[1:0]);
        case (info.lsu_size)
            SZ_B: shadow[a[9:2]][lane*8 +: 8] = info.rs2[7:0];
            SZ_H: shadow[a[9:2]][lane*8 +: 16] = info.rs2[15:0];
            default: shadow[a[9:2]] = info.rs2;
        endcase
    endtask

    function automatic dec2ex_s make_alu(logic [3:0] opc, logic imm_sel, logic wen);
        dec2ex_s info;
        info = '0;
        info.grp = GRP_ALU;
        info.alu_op = alu_op_e'(opc);
        info.use_imm = imm_sel;
        info.rs1 = $random(seed);
        info.rs2 = $random(seed);
        info.imm = $random(seed);
        info.rdwen = wen;
        info.rdidx = reg_idx_t'($random(seed));
        return info;
    endfunction

    function automatic dec2ex_s make_mem(logic st, lsu_size_e sz, logic uns, logic [7:0] word,
                                         logic [1:0] off);
        dec2ex_s info;
        info = make_alu(4'd0, 1'b0, !st);
        info.grp = GRP_LSU;
        info.lsu_store = st;
        info.lsu_size = sz;
        info.lsu_unsign = uns;
        info.imm = data_t'($random(seed) % 64);
        info.rs1 = {22'd0, word, off} - info.imm;
        return info;
    endfunction

    // drive one instruction and record what it should produce
    task automatic send(dec2ex_s info);
        int cnt;
        ex_vld_i = 1'b1;
        ex_info_i = info;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!ex_fire && cnt < TIMEOUT);
        if (!ex_fire) begin
            $display("timeout at %0t: instruction never accepted", $time);
            failures++;
        end else if (info.grp == GRP_ALU) begin
            if (info.rdwen) alu_q.push_back({info.rdidx, exp_result(info)});
        end else if (info.grp == GRP_LSU) begin
            if (info.lsu_store) apply_store(info);
            else if (info.rdwen) lsu_q.push_back({info.rdidx, exp_result(info)});
        end else begin
            faults_exp++;
        end
        ex_vld_i = 1'b0;
    endtask

    // ****************************************
    // write-back checker
    // ****************************************
    always @(posedge clk) begin
        ex_fire <= ex_vld_i && ex_rdy_o;
        wen_q   <= reg_wen_o;
        fault_q <= fault_o;
        got_q   <= {reg_waddr_o, reg_wdata_o};
    end

    always @(negedge clk) begin
        if (fault_q) faults_got++;
        if (wen_q) begin
            if (lsu_q.size() > 0 && lsu_q[0] == got_q) begin
                lsu_q.pop_front();
            end else begin
                assert (alu_q.size() > 0 && alu_q[0] == got_q) else begin
                    $display("Mismatch at %0t: unexpected write x%0d = %h", $time,
                             got_q.rdidx, got_q.data);
                    mismatches++;
                end
                if (alu_q.size() > 0 && alu_q[0] == got_q) alu_q.pop_front();
            end
        end
    end

    initial begin
        dec2ex_s info;
        logic [7:0] w;
        int cnt;
        int sel;
        for (int i = 0; i < 256; i++) begin
            w = 8'(i);
            shadow[i] = {w ^ 8'h3c, ~w, w, w + 8'h11};
        end
        repeat (3) @(negedge clk);
        rst_i = 1'b0;

        for (int op = 0; op < 10; op++) begin   // every op, both operand kinds
            send(make_alu(4'(op), 1'b0, 1'b1));
            send(make_alu(4'(op), 1'b1, 1'b1));
        end
        for (int off = 0; off < 4; off++) begin
            w = 8'(off * 7 + 3);
            send(make_mem(1'b1, SZ_W, 1'b0, w, 2'd0));
            send(make_mem(1'b0, SZ_B, 1'b0, w, 2'(off)));
            send(make_mem(1'b0, SZ_B, 1'b1, w, 2'(off)));
            send(make_mem(1'b0, SZ_H, 1'b0, w, 2'(off & 2)));
            send(make_mem(1'b0, SZ_H, 1'b1, w, 2'(off & 2)));
            send(make_mem(1'b1, SZ_B, 1'b0, w, 2'(off)));
            send(make_mem(1'b1, SZ_H, 1'b0, w, 2'(2 - (off & 2))));
            send(make_mem(1'b0, SZ_W, 1'b0, w, 2'd0));
        end
        for (int i = 0; i < N_MIXED; i++) begin
            sel = {$random(seed)} % 8;
            cnt = {$random(seed)} % 3;
            w = 8'($random(seed));
            if (sel < 4) begin
                send(make_alu(4'({$random(seed)} % 10), 1'($random(seed)), 1'b1));
            end else if (sel == 7) begin
                send(make_alu(4'({$random(seed)} % 10), 1'b0, 1'b0));   // no destination
            end else begin
                info = make_mem(sel == 6, lsu_size_e'(2'(cnt)), 1'($random(seed)), w,
                                cnt == 2 ? 2'd0 : cnt == 1 ? 2'({$random(seed)} % 2 * 2)
                                                          : 2'($random(seed)));
                info.rdwen = (sel == 4);
                send(info);
            end
        end
        info = make_alu(4'd0, 1'b0, 1'b1);
        info.grp = GRP_RSV2;
        send(info);
        info.grp = GRP_RSV3;
        send(info);

        cnt = 0;
        while ((alu_q.size() > 0 || lsu_q.size() > 0) && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        repeat (10) @(negedge clk);
        assert (alu_q.size() == 0 && lsu_q.size() == 0) else begin
            $display("write-backs missing after drain: %0d alu, %0d lsu", alu_q.size(),
                     lsu_q.size());
            failures++;
        end
        assert (faults_got == faults_exp) else begin
            $display("Mismatch at %0t: fault pulses %0d, expected %0d", $time, faults_got,
                     faults_exp);
            mismatches++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
